// ==== source/branchPredPkg.sv ====
// Branch predictor shared types
`default_nettype none

package branchPredPkg;

    // Two-bit saturating counter states, ordered so taken states have the MSB set
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } counterState;

    // Width of an instruction address
    localparam int defaultDataWidth = 16;

    // Low address bits passed straight into the table index
    localparam int defaultPreservedBits = 3;

    // Table index width, depth is 2**defaultHashWidth
    localparam int defaultHashWidth = 6;

endpackage : branchPredPkg

`default_nettype wire

// ==== source/predictorUpdateIf.sv ====
// Predictor table update bus
`default_nettype none

interface predictorUpdateIf
    import branchPredPkg::*;
#(
    parameter int dataWidth = defaultDataWidth,
    parameter int hashWidth = defaultHashWidth
);

    // One resolved branch from execute, already hashed
    logic                 write;
    logic [hashWidth-1:0] index;
    logic [dataWidth-1:0] address;
    logic                 taken;
    logic [dataWidth-1:0] target;

    // Top level drives the bus
    modport source (output write, output index, output address, output taken, output target);

    // Tables only observe it
    modport sink (input write, input index, input address, input taken, input target);

endinterface : predictorUpdateIf

`default_nettype wire

// ==== source/addressHash.sv ====
// Fetch address hash
`default_nettype none

module addressHash
    import branchPredPkg::*;
#(
    parameter int dataWidth     = defaultDataWidth,
    parameter int preservedBits = defaultPreservedBits,
    parameter int hashWidth     = defaultHashWidth
) (
    input  wire logic [dataWidth-1:0] address,
    output      logic [hashWidth-1:0] hashedAddress
);

    localparam int localWidth = hashWidth - preservedBits;

    // Reject configurations the folding below cannot handle
    if (dataWidth != 8 && dataWidth != 16 && dataWidth != 32 && dataWidth != 64) begin : badWidth
        $error("addressHash: dataWidth %0d is not 8, 16, 32 or 64", dataWidth);
    end
    if (preservedBits < 1 || preservedBits > hashWidth) begin : badPreserved
        $error("addressHash: preservedBits %0d outside 1..%0d", preservedBits, hashWidth);
    end

    logic [preservedBits-1:0] preservedLow;
    logic [dataWidth-1:0]     hashInput;
    logic [7:0]               byteSum;

    assign preservedLow = address[preservedBits-1:0];

    // Upper bits stay in place, preserved bits are zeroed
    assign hashInput = {address[dataWidth-1:preservedBits], {preservedBits{1'b0}}};

    // Bytewise checksum, modulo 256
    if (dataWidth == 8) begin : sum8
        assign byteSum = hashInput;
    end else if (dataWidth == 16) begin : sum16
        assign byteSum = hashInput[15:8] + hashInput[7:0];
    end else if (dataWidth == 32) begin : sum32
        logic [7:0] lowPair;
        logic [7:0] highPair;
        assign lowPair  = hashInput[15:8] + hashInput[7:0];
        assign highPair = hashInput[31:24] + hashInput[23:16];
        assign byteSum  = lowPair + highPair;
    end else begin : sum64
        logic [7:0] pair0;
        logic [7:0] pair1;
        logic [7:0] pair2;
        logic [7:0] pair3;
        assign pair0   = hashInput[15:8] + hashInput[7:0];
        assign pair1   = hashInput[31:24] + hashInput[23:16];
        assign pair2   = hashInput[47:40] + hashInput[39:32];
        assign pair3   = hashInput[63:56] + hashInput[55:48];
        assign byteSum = (pair0 + pair1) + (pair2 + pair3);
    end

    // Fold the checksum down to the remaining index bits
    if (localWidth == 0) begin : noUpper
        assign hashedAddress = preservedLow;
    end else if (localWidth < 5) begin : nibbleFold
        logic [3:0] nibbleSum;
        assign nibbleSum     = byteSum[7:4] + byteSum[3:0];
        assign hashedAddress = {nibbleSum[localWidth-1:0], preservedLow};
    end else if (localWidth < 9) begin : byteFold
        assign hashedAddress = {byteSum[localWidth-1:0], preservedLow};
    end else begin : wideIndex
        // Checksum is too narrow to fill the upper part
        assign hashedAddress = {{localWidth{1'b0}}, preservedLow};
    end

endmodule : addressHash

`default_nettype wire

// ==== source/patternHistoryTable.sv ====
// Pattern history table
`default_nettype none

module patternHistoryTable
    import branchPredPkg::*;
#(
    parameter int hashWidth = defaultHashWidth
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic [hashWidth-1:0] readIndex,
    predictorUpdateIf.sink            update,
    output      logic                 readTaken
);

    localparam int depth = 2 ** hashWidth;

    counterState counters [depth];
    counterState currentState;
    counterState nextState;

    assign currentState = counters[update.index];

    // Saturating step toward the resolved direction
    always_comb begin
        nextState = currentState;
        if (update.taken) begin
            case (currentState)
                strongNotTaken: nextState = weakNotTaken;
                weakNotTaken:   nextState = weakTaken;
                weakTaken:      nextState = strongTaken;
                default:        nextState = strongTaken;
            endcase
        end else begin
            case (currentState)
                strongTaken:    nextState = weakTaken;
                weakTaken:      nextState = weakNotTaken;
                weakNotTaken:   nextState = strongNotTaken;
                default:        nextState = strongNotTaken;
            endcase
        end
    end

    // Read samples the old counter when it collides with a write
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                counters[i] <= weakNotTaken;
            end
            readTaken <= 1'b0;
        end else begin
            if (update.write) begin
                counters[update.index] <= nextState;
            end
            readTaken <= counters[readIndex][1];
        end
    end

    // A written counter must hold a defined state afterwards
    assert property (@(posedge clk) disable iff (!rstN)
        update.write |=> !$isunknown(counters[$past(update.index)]))
    else $error("patternHistoryTable: counter unknown after update");

endmodule : patternHistoryTable

`default_nettype wire

// ==== source/branchTargetBuffer.sv ====
// Branch target buffer
`default_nettype none

module branchTargetBuffer
    import branchPredPkg::*;
#(
    parameter int dataWidth = defaultDataWidth,
    parameter int hashWidth = defaultHashWidth
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic [hashWidth-1:0] readIndex,
    input  wire logic [dataWidth-1:0] readAddress,
    predictorUpdateIf.sink            update,
    output      logic                 readHit,
    output      logic [dataWidth-1:0] readTarget
);

    localparam int depth = 2 ** hashWidth;

    logic [depth-1:0]     valid;
    logic [dataWidth-1:0] tags    [depth];
    logic [dataWidth-1:0] targets [depth];
    logic                 hit;
    logic                 allocate;

    // Only taken branches claim an entry
    assign allocate = update.write && update.taken;

    // Full address tag, so aliasing indexes never produce a false hit
    assign hit = valid[readIndex] && (tags[readIndex] == readAddress);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid <= '0;
        end else if (allocate) begin
            valid[update.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            tags[update.index]    <= update.address;
            targets[update.index] <= update.target;
        end
    end

    // Registered read port, target zeroed on a miss
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readHit    <= 1'b0;
            readTarget <= '0;
        end else begin
            readHit    <= hit;
            readTarget <= hit ? targets[readIndex] : '0;
        end
    end

    // A defined index must give a defined hit on the next cycle
    assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(readIndex) |=> !$isunknown(readHit))
    else $error("branchTargetBuffer: readHit unknown");

endmodule : branchTargetBuffer

`default_nettype wire

// ==== source/branchPredictor.sv ====
// Branch predictor top level
`default_nettype none

module branchPredictor
    import branchPredPkg::*;
#(
    parameter int dataWidth     = defaultDataWidth,
    parameter int preservedBits = defaultPreservedBits,
    parameter int hashWidth     = defaultHashWidth
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,

    // Lookup from fetch
    input  wire logic                 lookupValid,
    input  wire logic [dataWidth-1:0] lookupAddress,
    output      logic                 predictValid,
    output      logic                 predictHit,
    output      logic                 predictTaken,
    output      logic [dataWidth-1:0] predictTarget,

    // Resolved branch from execute
    input  wire logic                 updateValid,
    input  wire logic [dataWidth-1:0] updateAddress,
    input  wire logic                 updateTaken,
    input  wire logic [dataWidth-1:0] updateTarget
);

    logic [hashWidth-1:0] lookupIndex;
    logic                 counterTaken;
    logic                 bufferHit;
    logic [dataWidth-1:0] bufferTarget;

    predictorUpdateIf #(
        .dataWidth (dataWidth),
        .hashWidth (hashWidth)
    ) updateBus ();

    addressHash #(
        .dataWidth     (dataWidth),
        .preservedBits (preservedBits),
        .hashWidth     (hashWidth)
    ) lookupHash (
        .address       (lookupAddress),
        .hashedAddress (lookupIndex)
    );

    // Update side hashes straight onto the bus index
    addressHash #(
        .dataWidth     (dataWidth),
        .preservedBits (preservedBits),
        .hashWidth     (hashWidth)
    ) updateHash (
        .address       (updateAddress),
        .hashedAddress (updateBus.index)
    );

    assign updateBus.write   = updateValid;
    assign updateBus.address = updateAddress;
    assign updateBus.taken   = updateTaken;
    assign updateBus.target  = updateTarget;

    patternHistoryTable #(
        .hashWidth (hashWidth)
    ) patternHistoryTable_i (
        .clk       (clk),
        .rstN      (rstN),
        .readIndex (lookupIndex),
        .update    (updateBus),
        .readTaken (counterTaken)
    );

    branchTargetBuffer #(
        .dataWidth (dataWidth),
        .hashWidth (hashWidth)
    ) branchTargetBuffer_i (
        .clk         (clk),
        .rstN        (rstN),
        .readIndex   (lookupIndex),
        .readAddress (lookupAddress),
        .update      (updateBus),
        .readHit     (bufferHit),
        .readTarget  (bufferTarget)
    );

    // Results leave the tables one cycle after the strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            predictValid <= 1'b0;
        end else begin
            predictValid <= lookupValid;
        end
    end

    assign predictHit    = bufferHit;
    assign predictTaken  = bufferHit && counterTaken;
    assign predictTarget = bufferTarget;

endmodule : branchPredictor

`default_nettype wire

// ==== verification/branchPredictorTb.sv ====
// Branch predictor testbench
`default_nettype none

module branchPredictorTb
    import branchPredPkg::*;
;

    localparam int dataWidth     = defaultDataWidth;
    localparam int preservedBits = defaultPreservedBits;
    localparam int hashWidth     = defaultHashWidth;
    localparam int depth         = 2 ** hashWidth;
    localparam int randomCycles  = 400;
    localparam int waitLimit     = 10;

    // One directed step, either a lookup with its expected result or an update
    typedef struct {
        bit                   isUpdate;
        logic [dataWidth-1:0] address;
        bit                   taken;
        logic [dataWidth-1:0] target;
        bit                   expHit;
        bit                   expTaken;
        logic [dataWidth-1:0] expTarget;
    } stepEntry;

    logic                 clk;
    logic                 rstN;
    logic                 lookupValid;
    logic [dataWidth-1:0] lookupAddress;
    logic                 predictValid;
    logic                 predictHit;
    logic                 predictTaken;
    logic [dataWidth-1:0] predictTarget;
    logic                 updateValid;
    logic [dataWidth-1:0] updateAddress;
    logic                 updateTaken;
    logic [dataWidth-1:0] updateTarget;

    stepEntry steps[$];
    int       mismatchCount;
    int       failureCount;
    logic [31:0] rngState;

    // Reference state of both tables
    counterState          counterModel [depth];
    bit                   validModel   [depth];
    logic [dataWidth-1:0] tagModel     [depth];
    logic [dataWidth-1:0] targetModel  [depth];

    branchPredictor branchPredictor_i (
        .clk           (clk),
        .rstN          (rstN),
        .lookupValid   (lookupValid),
        .lookupAddress (lookupAddress),
        .predictValid  (predictValid),
        .predictHit    (predictHit),
        .predictTaken  (predictTaken),
        .predictTarget (predictTarget),
        .updateValid   (updateValid),
        .updateAddress (updateAddress),
        .updateTaken   (updateTaken),
        .updateTarget  (updateTarget)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Low bits kept, upper index bits from the folded byte checksum
    function automatic logic [hashWidth-1:0] modelHash(input logic [dataWidth-1:0] address);
        logic [dataWidth-1:0] word;
        logic [7:0]           byteSum;
        logic [3:0]           nibbleSum;
        int                   localWidth;
        int                   upper;
        localWidth = hashWidth - preservedBits;
        word = address;
        for (int i = 0; i < preservedBits; i++) begin
            word[i] = 1'b0;
        end
        byteSum = 8'h00;
        for (int i = 0; i < dataWidth / 8; i++) begin
            byteSum = byteSum + word[8*i +: 8];
        end
        nibbleSum = byteSum[7:4] + byteSum[3:0];
        if (localWidth < 5) begin
            upper = int'(nibbleSum) & ((1 << localWidth) - 1);
        end else if (localWidth <= 8) begin
            upper = int'(byteSum) & ((1 << localWidth) - 1);
        end else begin
            upper = 0;
        end
        return hashWidth'((upper << preservedBits)
                          | (int'(address) & ((1 << preservedBits) - 1)));
    endfunction

    task automatic predictFromModel(input logic [dataWidth-1:0] address, output bit hit,
                                    output bit taken, output logic [dataWidth-1:0] target);
        logic [hashWidth-1:0] idx;
        idx = modelHash(address);
        hit = validModel[idx] && (tagModel[idx] == address);
        taken = hit && (counterModel[idx] == weakTaken || counterModel[idx] == strongTaken);
        target = hit ? targetModel[idx] : '0;
    endtask

    // Saturating counter step, buffer written only on taken
    task automatic stepModel(input logic [dataWidth-1:0] address, input bit taken,
                             input logic [dataWidth-1:0] target);
        logic [hashWidth-1:0] idx;
        idx = modelHash(address);
        if (taken && counterModel[idx] != strongTaken) begin
            counterModel[idx] = counterState'(counterModel[idx] + 2'd1);
        end else if (!taken && counterModel[idx] != strongNotTaken) begin
            counterModel[idx] = counterState'(counterModel[idx] - 2'd1);
        end
        if (taken) begin
            validModel[idx]  = 1'b1;
            tagModel[idx]    = address;
            targetModel[idx] = target;
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("mismatch at time %0t: %s expected %h, got %h", $time, name, expected,
                     actual);
        end
    endtask

    task automatic expectLookup(input logic [dataWidth-1:0] address, input bit hit,
                                input bit taken, input logic [dataWidth-1:0] target);
        stepEntry e;
        e = '{1'b0, address, 1'b0, '0, hit, taken, target};
        steps.push_back(e);
    endtask

    task automatic scheduleUpdate(input logic [dataWidth-1:0] address, input bit taken,
                                  input logic [dataWidth-1:0] target);
        stepEntry e;
        e = '{1'b1, address, taken, target, 1'b0, 1'b0, '0};
        steps.push_back(e);
    endtask

    // Inputs change on the falling edge, outputs are read there too
    task automatic applyStep(input stepEntry e);
        int waitCount;
        @(negedge clk);
        if (e.isUpdate) begin
            updateValid   = 1'b1;
            updateAddress = e.address;
            updateTaken   = e.taken;
            updateTarget  = e.target;
            stepModel(e.address, e.taken, e.target);
            @(negedge clk);
            updateValid = 1'b0;
        end else begin
            lookupValid   = 1'b1;
            lookupAddress = e.address;
            @(negedge clk);
            lookupValid = 1'b0;
            waitCount = 0;
            while (!predictValid && waitCount < waitLimit) begin
                @(negedge clk);
                waitCount++;
            end
            if (!predictValid) begin
                failureCount++;
                $display("No prediction arrived for lookup of address %h", e.address);
            end else begin
                checkValue("predictHit", 32'(e.expHit), 32'(predictHit));
                checkValue("predictTaken", 32'(e.expTaken), 32'(predictTaken));
                checkValue("predictTarget", 32'(e.expTarget), 32'(predictTarget));
            end
        end
    endtask

    task automatic runRandomPhase();
        logic [31:0]          r;
        logic [dataWidth-1:0] lookAddr;
        logic [dataWidth-1:0] updAddr;
        logic [dataWidth-1:0] updTarget;
        bit                   lookOn;
        bit                   updOn;
        bit                   updTaken;
        bit                   pendValid;
        bit                   pendHit;
        bit                   pendTaken;
        logic [dataWidth-1:0] pendTarget;
        pendValid = 1'b0;
        pendHit = 1'b0;
        pendTaken = 1'b0;
        pendTarget = '0;
        for (int cycle = 0; cycle <= randomCycles; cycle++) begin
            @(negedge clk);
            checkValue("predictValid", 32'(pendValid), 32'(predictValid));
            if (pendValid) begin
                checkValue("predictHit", 32'(pendHit), 32'(predictHit));
                checkValue("predictTaken", 32'(pendTaken), 32'(predictTaken));
                checkValue("predictTarget", 32'(pendTarget), 32'(predictTarget));
            end
            r = xorshift();
            // Narrow address pool so entries alias and get reused
            lookAddr = r[31:16] & 16'h0319;
            lookOn = (cycle < randomCycles) && (r[0] || r[1]);
            updOn = (cycle < randomCycles) && r[2];
            updTaken = r[3] || r[4];
            updTarget = dataWidth'(xorshift());
            if (r[5] && r[6]) begin
                updAddr = lookAddr;
            end else begin
                updAddr = dataWidth'(xorshift()) & 16'h0319;
            end
            // Lookup sees the tables before this edge's update
            pendValid = lookOn;
            predictFromModel(lookAddr, pendHit, pendTaken, pendTarget);
            if (updOn) begin
                stepModel(updAddr, updTaken, updTarget);
            end
            lookupValid   = lookOn;
            lookupAddress = lookAddr;
            updateValid   = updOn;
            updateAddress = updAddr;
            updateTaken   = updTaken;
            updateTarget  = updTarget;
        end
    endtask

    initial begin
        logic [dataWidth-1:0] addrA;
        logic [dataWidth-1:0] addrB;
        logic [dataWidth-1:0] aliasAddr;
        rstN = 1'b0;
        lookupValid = 1'b0;
        lookupAddress = '0;
        updateValid = 1'b0;
        updateAddress = '0;
        updateTaken = 1'b0;
        updateTarget = '0;
        mismatchCount = 0;
        failureCount = 0;
        rngState = 32'h5640;
        for (int i = 0; i < depth; i++) begin
            counterModel[i] = weakNotTaken;
            validModel[i] = 1'b0;
            tagModel[i] = '0;
            targetModel[i] = '0;
        end

        addrA = 16'h0100;
        addrB = 16'h0208;
        aliasAddr = addrA + 16'd8;
        while (modelHash(aliasAddr) != modelHash(addrA) && aliasAddr < 16'hFFF0) begin
            aliasAddr = aliasAddr + 16'd8;
        end
        if (modelHash(aliasAddr) != modelHash(addrA)) begin
            failureCount++;
            $display("Could not find an address that aliases %h", addrA);
        end

        // Empty tables miss everywhere
        expectLookup(16'h1234, 1'b0, 1'b0, '0);
        // One taken step from weakNotTaken already reaches weakTaken
        scheduleUpdate(addrA, 1'b1, 16'h0200);
        expectLookup(addrA, 1'b1, 1'b1, 16'h0200);
        // Saturate, then walk back down
        scheduleUpdate(addrB, 1'b1, 16'h0400);
        scheduleUpdate(addrB, 1'b1, 16'h0400);
        scheduleUpdate(addrB, 1'b1, 16'h0400);
        expectLookup(addrB, 1'b1, 1'b1, 16'h0400);
        scheduleUpdate(addrB, 1'b0, 16'h0BAD);
        expectLookup(addrB, 1'b1, 1'b1, 16'h0400);
        scheduleUpdate(addrB, 1'b0, 16'h0BAD);
        expectLookup(addrB, 1'b1, 1'b0, 16'h0400);
        // Alias evicts the first entry, shared counter moves to strongTaken
        scheduleUpdate(aliasAddr, 1'b1, 16'h0ABC);
        expectLookup(addrA, 1'b0, 1'b0, '0);
        expectLookup(aliasAddr, 1'b1, 1'b1, 16'h0ABC);
        expectLookup(16'h1234, 1'b0, 1'b0, '0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        foreach (steps[i]) begin
            applyStep(steps[i]);
        end
        runRandomPhase();

        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : branchPredictorTb

`default_nettype wire

// ==== branchPredictor.f ====
source/branchPredPkg.sv
source/predictorUpdateIf.sv
source/addressHash.sv
source/patternHistoryTable.sv
source/branchTargetBuffer.sv
source/branchPredictor.sv
verification/branchPredictorTb.sv

// ==== Bender.yml ====
package:
  name: branchPredictor

sources:
  - files:
      - source/branchPredPkg.sv
      - source/predictorUpdateIf.sv
      - source/addressHash.sv
      - source/patternHistoryTable.sv
      - source/branchTargetBuffer.sv
      - source/branchPredictor.sv
  - target: test
    files:
      - verification/branchPredictorTb.sv
